// ==== src/ethRxSettings.svh ====
`ifndef ETH_RX_SETTINGS_SVH
`define ETH_RX_SETTINGS_SVH

// Legal frame lengths in bytes, FCS included.
`define RX_MIN_FRAME 64
`define RX_MAX_FRAME 1518

// CRC32 preset value.
`define CRC_SEED 32'hFFFF_FFFF

// Register value left after a good frame plus its FCS, in engine bit order.
`define CRC_RESIDUE 32'hC704_DD7B

`endif

// ==== src/ethRxPkg.sv ====
package ethRxPkg;

  typedef logic [7:0] byteT;       // One stream octet.
  typedef logic [31:0] crcT;       // CRC register value.
  typedef logic [10:0] frameLenT;  // Byte count, saturates at 2047.

  // Per-frame result, reported once at end of frame.
  typedef struct packed {
    logic     crcError;
    logic     runt;
    logic     giant;
    frameLenT length;
  } frameStatusT;

  typedef enum logic {
    Idle,
    InFrame
  } lenStateT;

endpackage

// ==== src/fcsCalc.sv ====
`timescale 1ns/100ps
`include "ethRxSettings.svh"

module fcsCalc import ethRxPkg::*; (
  input  logic Clk,
  input  logic Reset,
  input  byteT RxData,
  input  logic RxValid,
  input  logic RxSof,
  output crcT  CrcNext
);

  crcT  crcQ;
  crcT  crcIn;
  byteT dataRev;

  // First byte of a frame starts from the seed.
  assign crcIn = RxSof ? `CRC_SEED : crcQ;

  // LSB of the octet goes on the wire first.
  assign dataRev = {RxData[0], RxData[1], RxData[2], RxData[3],
                    RxData[4], RxData[5], RxData[6], RxData[7]};

  assign CrcNext[0]  = crcIn[24] ^ crcIn[30] ^ dataRev[0] ^ dataRev[6];
  assign CrcNext[1]  = crcIn[24] ^ crcIn[25] ^ crcIn[30] ^ crcIn[31] ^
    dataRev[0] ^ dataRev[1] ^ dataRev[6] ^ dataRev[7];
  assign CrcNext[2]  = crcIn[24] ^ crcIn[25] ^ crcIn[26] ^ crcIn[30] ^ crcIn[31] ^
    dataRev[0] ^ dataRev[1] ^ dataRev[2] ^ dataRev[6] ^ dataRev[7];
  assign CrcNext[3]  = crcIn[25] ^ crcIn[26] ^ crcIn[27] ^ crcIn[31] ^
    dataRev[1] ^ dataRev[2] ^ dataRev[3] ^ dataRev[7];
  assign CrcNext[4]  = crcIn[24] ^ crcIn[26] ^ crcIn[27] ^ crcIn[28] ^ crcIn[30] ^
    dataRev[0] ^ dataRev[2] ^ dataRev[3] ^ dataRev[4] ^ dataRev[6];
  assign CrcNext[5]  = crcIn[24] ^ crcIn[25] ^ crcIn[27] ^ crcIn[28] ^ crcIn[29] ^
    crcIn[30] ^ crcIn[31] ^ dataRev[0] ^ dataRev[1] ^ dataRev[3] ^
    dataRev[4] ^ dataRev[5] ^ dataRev[6] ^ dataRev[7];
  assign CrcNext[6]  = crcIn[25] ^ crcIn[26] ^ crcIn[28] ^ crcIn[29] ^ crcIn[30] ^
    crcIn[31] ^ dataRev[1] ^ dataRev[2] ^ dataRev[4] ^ dataRev[5] ^
    dataRev[6] ^ dataRev[7];
  assign CrcNext[7]  = crcIn[24] ^ crcIn[26] ^ crcIn[27] ^ crcIn[29] ^ crcIn[31] ^
    dataRev[0] ^ dataRev[2] ^ dataRev[3] ^ dataRev[5] ^ dataRev[7];
  assign CrcNext[8]  = crcIn[0] ^ crcIn[24] ^ crcIn[25] ^ crcIn[27] ^ crcIn[28] ^
    dataRev[0] ^ dataRev[1] ^ dataRev[3] ^ dataRev[4];
  assign CrcNext[9]  = crcIn[1] ^ crcIn[25] ^ crcIn[26] ^ crcIn[28] ^ crcIn[29] ^
    dataRev[1] ^ dataRev[2] ^ dataRev[4] ^ dataRev[5];
  assign CrcNext[10] = crcIn[2] ^ crcIn[24] ^ crcIn[26] ^ crcIn[27] ^ crcIn[29] ^
    dataRev[0] ^ dataRev[2] ^ dataRev[3] ^ dataRev[5];
  assign CrcNext[11] = crcIn[3] ^ crcIn[24] ^ crcIn[25] ^ crcIn[27] ^ crcIn[28] ^
    dataRev[0] ^ dataRev[1] ^ dataRev[3] ^ dataRev[4];
  assign CrcNext[12] = crcIn[4] ^ crcIn[24] ^ crcIn[25] ^ crcIn[26] ^ crcIn[28] ^
    crcIn[29] ^ crcIn[30] ^ dataRev[0] ^ dataRev[1] ^ dataRev[2] ^
    dataRev[4] ^ dataRev[5] ^ dataRev[6];
  assign CrcNext[13] = crcIn[5] ^ crcIn[25] ^ crcIn[26] ^ crcIn[27] ^ crcIn[29] ^
    crcIn[30] ^ crcIn[31] ^ dataRev[1] ^ dataRev[2] ^ dataRev[3] ^
    dataRev[5] ^ dataRev[6] ^ dataRev[7];
  assign CrcNext[14] = crcIn[6] ^ crcIn[26] ^ crcIn[27] ^ crcIn[28] ^ crcIn[30] ^
    crcIn[31] ^ dataRev[2] ^ dataRev[3] ^ dataRev[4] ^ dataRev[6] ^ dataRev[7];
  assign CrcNext[15] = crcIn[7] ^ crcIn[27] ^ crcIn[28] ^ crcIn[29] ^ crcIn[31] ^
    dataRev[3] ^ dataRev[4] ^ dataRev[5] ^ dataRev[7];
  assign CrcNext[16] = crcIn[8] ^ crcIn[24] ^ crcIn[28] ^ crcIn[29] ^
    dataRev[0] ^ dataRev[4] ^ dataRev[5];
  assign CrcNext[17] = crcIn[9] ^ crcIn[25] ^ crcIn[29] ^ crcIn[30] ^
    dataRev[1] ^ dataRev[5] ^ dataRev[6];
  assign CrcNext[18] = crcIn[10] ^ crcIn[26] ^ crcIn[30] ^ crcIn[31] ^
    dataRev[2] ^ dataRev[6] ^ dataRev[7];
  assign CrcNext[19] = crcIn[11] ^ crcIn[27] ^ crcIn[31] ^ dataRev[3] ^ dataRev[7];
  assign CrcNext[20] = crcIn[12] ^ crcIn[28] ^ dataRev[4];
  assign CrcNext[21] = crcIn[13] ^ crcIn[29] ^ dataRev[5];
  assign CrcNext[22] = crcIn[14] ^ crcIn[24] ^ dataRev[0];
  assign CrcNext[23] = crcIn[15] ^ crcIn[24] ^ crcIn[25] ^ crcIn[30] ^
    dataRev[0] ^ dataRev[1] ^ dataRev[6];
  assign CrcNext[24] = crcIn[16] ^ crcIn[25] ^ crcIn[26] ^ crcIn[31] ^
    dataRev[1] ^ dataRev[2] ^ dataRev[7];
  assign CrcNext[25] = crcIn[17] ^ crcIn[26] ^ crcIn[27] ^ dataRev[2] ^ dataRev[3];
  assign CrcNext[26] = crcIn[18] ^ crcIn[24] ^ crcIn[27] ^ crcIn[28] ^ crcIn[30] ^
    dataRev[0] ^ dataRev[3] ^ dataRev[4] ^ dataRev[6];
  assign CrcNext[27] = crcIn[19] ^ crcIn[25] ^ crcIn[28] ^ crcIn[29] ^ crcIn[31] ^
    dataRev[1] ^ dataRev[4] ^ dataRev[5] ^ dataRev[7];
  assign CrcNext[28] = crcIn[20] ^ crcIn[26] ^ crcIn[29] ^ crcIn[30] ^
    dataRev[2] ^ dataRev[5] ^ dataRev[6];
  assign CrcNext[29] = crcIn[21] ^ crcIn[27] ^ crcIn[30] ^ crcIn[31] ^
    dataRev[3] ^ dataRev[6] ^ dataRev[7];
  assign CrcNext[30] = crcIn[22] ^ crcIn[28] ^ crcIn[31] ^ dataRev[4] ^ dataRev[7];
  assign CrcNext[31] = crcIn[23] ^ crcIn[29] ^ dataRev[5];

  always_ff @(posedge Clk or posedge Reset) begin
    if (Reset) begin
      crcQ <= `CRC_SEED;
    end else if (RxValid) begin
      crcQ <= CrcNext;  // Advance on every accepted byte.
    end
  end

endmodule

// ==== src/frameLength.sv ====
`timescale 1ns/100ps

module frameLength import ethRxPkg::*; (
  input  logic     Clk,
  input  logic     Reset,
  input  logic     RxValid,
  input  logic     RxSof,
  input  logic     RxEof,
  output frameLenT LenNext,
  output logic     Active
);

  lenStateT stateQ;
  frameLenT countQ;
  logic     countFull;

  // A start pulse opens a frame even while one is still open.
  assign Active = RxSof || (stateQ == InFrame);

  assign countFull = (countQ == '1);

  always_comb begin
    if (RxSof) begin
      LenNext = frameLenT'(1);  // Current byte is the first.
    end else if (countFull) begin
      LenNext = countQ;  // Hold at 2047.
    end else begin
      LenNext = countQ + frameLenT'(1);
    end
  end

  always_ff @(posedge Clk or posedge Reset) begin
    if (Reset) begin
      stateQ <= Idle;
      countQ <= '0;
    end else if (RxValid && Active) begin
      countQ <= LenNext;
      stateQ <= RxEof ? Idle : InFrame;  // Single-byte frame closes at once.
    end
  end

endmodule

// ==== src/frameStatus.sv ====
`timescale 1ns/100ps
`include "ethRxSettings.svh"

module frameStatus import ethRxPkg::*; (
  input  logic        Clk,
  input  logic        Reset,
  input  logic        RxValid,
  input  logic        RxEof,
  input  logic        Active,
  input  crcT         CrcNext,
  input  frameLenT    LenNext,
  output frameStatusT Status,
  output logic        StatusValid
);

  frameStatusT statusD;
  logic        frameEnd;

  // Stray end pulses outside a frame are dropped here.
  assign frameEnd = RxValid && Active && RxEof;

  always_comb begin
    statusD.crcError = (CrcNext != `CRC_RESIDUE);
    statusD.runt     = (LenNext < frameLenT'(`RX_MIN_FRAME));
    statusD.giant    = (LenNext > frameLenT'(`RX_MAX_FRAME));
    statusD.length   = LenNext;
  end

  always_ff @(posedge Clk or posedge Reset) begin
    if (Reset) begin
      Status      <= '0;
      StatusValid <= 1'b0;
    end else begin
      StatusValid <= frameEnd;  // One-cycle strobe.
      if (frameEnd) begin
        Status <= statusD;  // Held until the next frame ends.
      end
    end
  end

endmodule

// ==== src/ethRxCheck.sv ====
`timescale 1ns/100ps

module ethRxCheck import ethRxPkg::*; (
  input  logic        Clk,
  input  logic        Reset,
  input  byteT        RxData,
  input  logic        RxValid,
  input  logic        RxSof,
  input  logic        RxEof,
  output frameStatusT Status,
  output logic        StatusValid
);

  crcT      crcNext;
  frameLenT lenNext;
  logic     active;

  fcsCalc uFcsCalc (
    .Clk     (Clk),
    .Reset   (Reset),
    .RxData  (RxData),
    .RxValid (RxValid),
    .RxSof   (RxSof),
    .CrcNext (crcNext)
  );

  frameLength uFrameLength (
    .Clk     (Clk),
    .Reset   (Reset),
    .RxValid (RxValid),
    .RxSof   (RxSof),
    .RxEof   (RxEof),
    .LenNext (lenNext),
    .Active  (active)
  );

  frameStatus uFrameStatus (
    .Clk         (Clk),
    .Reset       (Reset),
    .RxValid     (RxValid),
    .RxEof       (RxEof),
    .Active      (active),
    .CrcNext     (crcNext),
    .LenNext     (lenNext),
    .Status      (Status),
    .StatusValid (StatusValid)
  );

endmodule

// ==== dv/tbClock.sv ====
`timescale 1ns/100ps

module tbClock (
  output logic Clk,
  output logic Reset
);

  initial begin
    Clk = 1'b0;
    forever #10 Clk = ~Clk;  // 20 ns period.
  end

  initial begin
    Reset = 1'b1;
    repeat (5) @(posedge Clk);
    #2 Reset = 1'b0;
  end

endmodule

// ==== dv/ethRxCheckTb.sv ====
`timescale 1ns/100ps
`include "ethRxSettings.svh"

module ethRxCheckTb import ethRxPkg::*; ();

  logic        Clk;
  logic        Reset;
  byteT        RxData;
  logic        RxValid;
  logic        RxSof;
  logic        RxEof;
  frameStatusT Status;
  logic        StatusValid;

  logic [31:0] lfsr = 32'h9375abbf;
  int          cycleCnt = 0;
  int          errors = 0;
  int          reportCnt = 0;
  frameStatusT lastStatus = '0;
  byteT        frameBuf[$];
  frameStatusT expQ[$];
  frameStatusT gotQ[$];
  int          expCycleQ[$];
  int          gotCycleQ[$];

  tbClock uClock (
    .Clk   (Clk),
    .Reset (Reset)
  );

  ethRxCheck dut (
    .Clk         (Clk),
    .Reset       (Reset),
    .RxData      (RxData),
    .RxValid     (RxValid),
    .RxSof       (RxSof),
    .RxEof       (RxEof),
    .Status      (Status),
    .StatusValid (StatusValid)
  );

  always @(posedge Clk) begin
    cycleCnt <= cycleCnt + 1;
  end

  // Status is stable mid-cycle.
  always @(negedge Clk) begin
    if (StatusValid === 1'b1) begin
      gotQ.push_back(Status);
      gotCycleQ.push_back(cycleCnt);
    end
  end

  // Galois LFSR stepped once per bit taken.
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
    end
    return val;
  endfunction

  // Standard Ethernet CRC32 over the first n bytes of frameBuf.
  function automatic logic [31:0] crcOf(input int n);
    logic [31:0] c;
    c = 32'hFFFF_FFFF;
    for (int i = 0; i < n; i++) begin
      c = c ^ {24'h0, frameBuf[i]};
      for (int b = 0; b < 8; b++) begin
        c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
      end
    end
    return ~c;
  endfunction

  function automatic void buildFrame(input int len);
    logic [31:0] fcs;
    frameBuf.delete();
    repeat (len - 4) begin
      frameBuf.push_back(byteT'(randBits(8)));
    end
    fcs = crcOf(len - 4);
    for (int i = 0; i < 4; i++) begin
      frameBuf.push_back(fcs[8*i +: 8]);  // LSB first.
    end
  endfunction

  function automatic void expectStatus(input int cyc);
    frameStatusT want;
    int          n;
    logic [31:0] fcs;
    n = frameBuf.size();
    fcs = {frameBuf[n-1], frameBuf[n-2], frameBuf[n-3], frameBuf[n-4]};
    want.crcError = (crcOf(n - 4) != fcs);
    want.runt = (n < `RX_MIN_FRAME);
    want.giant = (n > `RX_MAX_FRAME);
    want.length = (n > 2047) ? 11'd2047 : frameLenT'(n);
    expQ.push_back(want);
    expCycleQ.push_back(cyc);
  endfunction

  function automatic void checkField(input string name, input logic [13:0] got,
                                     input logic [13:0] want);
    if (got !== want) begin
      errors++;
      $display("FAIL %s got %h expected %h", name, got, want);
    end
  endfunction

  task automatic driveCycle(input logic valid, input byteT data, input logic sof,
                            input logic eof);
    @(posedge Clk);
    #2;
    RxValid = valid;
    RxData = data;
    RxSof = sof;
    RxEof = eof;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      driveCycle(1'b0, byteT'(randBits(8)), 1'b0, 1'b0);  // Garbage data.
    end
  endtask

  task automatic sendFrame(input bit withGaps, input bit withEof);
    int n;
    n = frameBuf.size();
    for (int i = 0; i < n; i++) begin
      if (withGaps && i > 0) begin
        idle(randBits(2));
      end
      driveCycle(1'b1, frameBuf[i], i == 0, withEof && (i == n - 1));
    end
    if (withEof) begin
      expectStatus(cycleCnt + 1);  // Strobe one cycle after the accepting edge.
    end
  endtask

  task automatic checkReports();
    int waited;
    waited = 0;
    while (gotQ.size() < expQ.size() && waited < 100) begin
      @(posedge Clk);
      #2;
      waited++;
    end
    if (gotQ.size() < expQ.size()) begin
      $display("Timed out waiting for StatusValid");
    end
    if (gotQ.size() != expQ.size()) begin
      errors++;
      $display("Got %0d status reports where %0d were expected", gotQ.size(),
               expQ.size());
    end
    for (int i = 0; i < gotQ.size() && i < expQ.size(); i++) begin
      checkField("Status.crcError", gotQ[i].crcError, expQ[i].crcError);
      checkField("Status.runt", gotQ[i].runt, expQ[i].runt);
      checkField("Status.giant", gotQ[i].giant, expQ[i].giant);
      checkField("Status.length", gotQ[i].length, expQ[i].length);
      if (gotCycleQ[i] != expCycleQ[i]) begin
        errors++;
        $display("StatusValid of report %0d came in cycle %0d instead of %0d", i,
                 gotCycleQ[i], expCycleQ[i]);
      end
    end
    if (expQ.size() > 0) begin
      lastStatus = expQ[expQ.size() - 1];
    end
    checkField("Status", Status, lastStatus);  // Held since the last report.
    reportCnt += expQ.size();
    gotQ.delete();
    gotCycleQ.delete();
    expQ.delete();
    expCycleQ.delete();
  endtask

  task automatic resetDefaults();
    int waited;
    waited = 0;
    while (Reset !== 1'b0 && waited < 50) begin
      @(posedge Clk);
      waited++;
    end
    if (Reset !== 1'b0) begin
      errors++;
      $display("Reset was never released");
    end
    repeat (4) begin
      @(posedge Clk);
      #2;
      checkField("StatusValid", StatusValid, 1'b0);
      checkField("Status", Status, '0);
    end
  endtask

  task automatic goodAndBadCrc();
    buildFrame(100);
    sendFrame(1'b0, 1'b1);
    idle(2);
    checkReports();
    frameBuf[20] = frameBuf[20] ^ 8'h40;  // Same frame with one payload bit off.
    sendFrame(1'b0, 1'b1);
    idle(2);
    checkReports();
  endtask

  task automatic lengthLimits();
    int lens[6] = '{40, 63, 64, 1518, 1519, 2100};
    foreach (lens[i]) begin
      buildFrame(lens[i]);
      sendFrame(1'b0, 1'b1);
      idle(2);
    end
    checkReports();
  endtask

  task automatic backToBackFrames();
    buildFrame(64);
    sendFrame(1'b0, 1'b1);
    buildFrame(80);
    sendFrame(1'b0, 1'b1);
    buildFrame(70);
    sendFrame(1'b0, 1'b1);
    buildFrame(90);
    sendFrame(1'b1, 1'b1);
    buildFrame(66);
    sendFrame(1'b1, 1'b1);
    idle(2);
    checkReports();
  endtask

  task automatic strayControls();
    driveCycle(1'b1, 8'h5A, 1'b0, 1'b1);  // End pulse with no open frame.
    idle(4);
    checkReports();
    buildFrame(90);
    sendFrame(1'b1, 1'b0);  // Left open.
    buildFrame(72);
    sendFrame(1'b1, 1'b1);
    idle(2);
    checkReports();
  endtask

  initial begin
    RxData = '0;
    RxValid = 1'b0;
    RxSof = 1'b0;
    RxEof = 1'b0;
    resetDefaults();
    goodAndBadCrc();
    lengthLimits();
    backToBackFrames();
    strayControls();
    $display("%0d status reports checked, %0d errors", reportCnt, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+src
src/ethRxPkg.sv
src/fcsCalc.sv
src/frameLength.sv
src/frameStatus.sv
src/ethRxCheck.sv
dv/tbClock.sv
dv/ethRxCheckTb.sv

// ==== Bender.yml ====
package:
  name: eth_rx_check

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/ethRxPkg.sv
      - src/fcsCalc.sv
      - src/frameLength.sv
      - src/frameStatus.sv
      - src/ethRxCheck.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/tbClock.sv
      - dv/ethRxCheckTb.sv
